/* compile.f */
verilog/pipe_pkg.sv
verilog/regfile.sv
verilog/decode_stage.sv
verilog/forward_unit.sv
verilog/execute_stage.sv
verilog/pipeline_top.sv
tb/pipe_checker.sv
tb/tb_pipeline.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_pipeline -f compile.f \
    --Mdir obj_dir -o tb_pipeline_sim

./obj_dir/tb_pipeline_sim | tee sim.log

if grep -qx "TB PASSED" sim.log; then
    exit 0
fi
echo "Simulation did not report a pass"
exit 1

/* tb/tb_pipeline.sv */
`default_nettype none

module tb_pipeline;
    timeunit 1ns;
    timeprecision 1ps;

    import pipe_pkg::*;

    localparam int CLK_HALF     = 20;
    localparam int RESET_CYCLES = 16;
    localparam int SEED         = 82177;
    localparam int DIRECTED_MAX = 100;
    localparam int RANDOM_COUNT = 500;
    localparam int MAX_GAP      = 3;
    localparam int DRAIN_CYCLES = 8;
    localparam int MARGIN       = 200;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + DIRECTED_MAX
        + RANDOM_COUNT * (MAX_GAP + 1) + DRAIN_CYCLES + MARGIN;

    logic      clk;
    logic      arst_n;
    instr_t    instr;
    logic      instr_valid;
    logic      wb_valid;
    reg_addr_t wb_reg;
    word_t     wb_data;
    logic      end_of_test;
    logic      reported;
    int        error_count;

    pipeline_top UUT (
        .clk (clk), .arst_n (arst_n),
        .instr (instr), .instr_valid (instr_valid),
        .wb_valid (wb_valid), .wb_reg (wb_reg), .wb_data (wb_data)
    );

    pipe_checker result_check (
        .clk (clk), .arst_n (arst_n),
        .instr (instr), .instr_valid (instr_valid),
        .wb_valid (wb_valid), .wb_reg (wb_reg), .wb_data (wb_data),
        .end_of_test (end_of_test), .reported (reported), .error_count (error_count)
    );

    initial clk = 1'b0;
    always #CLK_HALF clk = ~clk;

    //////////////////////////////////////////////////////////////
    // Instruction encoding and driving
    function automatic instr_t make_instr(input logic [3:0] opc, input reg_addr_t rd,
                                          input reg_addr_t rs1, input reg_addr_t rs2);
        return {opc, rd, rs1, rs2};
    endfunction

    function automatic instr_t make_li(input reg_addr_t rd, input logic [7:0] imm);
        return {4'(OP_LI), rd, imm};
    endfunction

    task automatic send_instr(input instr_t w);
        @(posedge clk);
        #2;
        instr       = w;
        instr_valid = 1'b1;
    endtask

    task automatic send_idle(input int cycles);
        repeat (cycles)
        begin
            @(posedge clk);
            #2;
            instr       = '0;
            instr_valid = 1'b0;
        end
    endtask

    //////////////////////////////////////////////////////////////
    // Directed streams
    task automatic run_basic_ops();
        // Every register reads zero after reset
        for (int r = 0; r < NUM_REGS; r += 2)
        begin
            send_instr(make_instr(OP_OR, 4'd1, 4'(r), 4'(r + 1)));
        end
        send_instr(make_li(4'd1, 8'h7F));
        send_instr(make_li(4'd2, 8'hFF));
        send_instr(make_instr(OP_ADD, 4'd3, 4'd1, 4'd2));
        send_instr(make_instr(OP_SUB, 4'd4, 4'd1, 4'd2));
        send_instr(make_instr(OP_AND, 4'd5, 4'd4, 4'd2));
        send_instr(make_instr(OP_OR, 4'd6, 4'd4, 4'd1));
        send_instr(make_instr(OP_XOR, 4'd7, 4'd4, 4'd6));
        // Negative and positive immediates
        send_instr(make_instr(OP_ADDI, 4'd8, 4'd1, 4'h8));
        send_instr(make_instr(OP_ADDI, 4'd9, 4'd0, 4'hF));
        send_instr(make_instr(OP_ADDI, 4'd10, 4'd9, 4'h7));
        send_instr(make_instr(OP_ADD, 4'd11, 4'd9, 4'd9));
        send_instr(make_instr(OP_SUB, 4'd12, 4'd0, 4'd2));
    endtask

    task automatic run_dependencies();
        // Distance one, two and three back to back
        send_instr(make_li(4'd5, 8'h03));
        send_instr(make_li(4'd6, 8'h04));
        send_instr(make_instr(OP_SUB, 4'd7, 4'd5, 4'd6));
        send_instr(make_instr(OP_ADD, 4'd8, 4'd5, 4'd6));
        send_instr(make_instr(OP_XOR, 4'd9, 4'd7, 4'd8));
        for (int i = 0; i < 5; i++)
        begin
            send_instr(make_instr(OP_ADDI, 4'd13, 4'd13, 4'h1));
        end
        send_instr(make_instr(OP_ADD, 4'd14, 4'd13, 4'd13));
        send_idle(1);
        send_instr(make_instr(OP_ADD, 4'd15, 4'd14, 4'd13));
    endtask

    task automatic run_no_writeback();
        send_instr(make_instr(OP_NOP, 4'd3, 4'd1, 4'd2));
        for (int opc = 8; opc < 16; opc++)
        begin
            send_instr(make_instr(4'(opc), 4'd3, 4'd1, 4'd2));
        end
        send_idle(3);
        send_instr(make_instr(OP_ADD, 4'd0, 4'd1, 4'd2));
        send_instr(make_li(4'd0, 8'hAA));
        send_instr(make_instr(OP_ADDI, 4'd0, 4'd1, 4'h5));
        // r0 still zero after the discarded writes
        send_instr(make_instr(OP_ADD, 4'd10, 4'd0, 4'd0));
        send_instr(make_instr(OP_ADDI, 4'd11, 4'd0, 4'h3));
        send_idle(2);
    endtask

    task automatic run_random_stream();
        logic [3:0] opc;
        for (int i = 0; i < RANDOM_COUNT; i++)
        begin
            if ($urandom_range(3, 0) != 0)
                opc = 4'($urandom_range(7, 1));
            else
                opc = 4'($urandom_range(15, 0));
            // Small register range keeps hazards frequent
            send_instr(make_instr(opc, 4'($urandom_range(7, 0)),
                                  4'($urandom_range(7, 0)), 4'($urandom_range(15, 0))));
            if ($urandom_range(3, 0) == 0)
                send_idle($urandom_range(MAX_GAP, 1));
        end
    endtask

    //////////////////////////////////////////////////////////////
    // Main sequence
    initial
    begin
        void'($urandom(SEED));
        arst_n      = 1'b1;
        instr       = '0;
        instr_valid = 1'b0;
        end_of_test = 1'b0;
        #1;
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        arst_n = 1'b1;
        send_idle(4);
        run_basic_ops();
        run_dependencies();
        run_no_writeback();
        run_random_stream();
        send_idle(DRAIN_CYCLES);
        end_of_test = 1'b1;
        wait (reported);
        if (error_count == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

    // Watchdog
    initial
    begin
        #(WATCHDOG_CYCLES * 2 * CLK_HALF);
        $display("Watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/pipe_checker.sv */
`default_nettype none

module pipe_checker (
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  wire pipe_pkg::instr_t    instr,
    input  wire logic                instr_valid,
    input  wire logic                wb_valid,
    input  wire pipe_pkg::reg_addr_t wb_reg,
    input  wire pipe_pkg::word_t     wb_data,
    input  wire logic                end_of_test,
    output logic                     reported,
    output int                       error_count
);
    timeunit 1ns;
    timeprecision 1ps;

    import pipe_pkg::*;

    word_t     model_regs [NUM_REGS];
    reg_addr_t exp_reg_q [$];
    word_t     exp_data_q [$];
    int        check_count;
    int        mismatch_count;
    int        unexpected_count;
    int        leftover_count;

    //////////////////////////////////////////////////////////////
    // Reference rules
    function automatic bit ref_writes(input instr_t ins);
        logic [3:0] opc;
        opc = ins[15:12];
        if (ins[11:8] == 4'h0)
            return 1'b0;
        return opc inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_LI};
    endfunction

    function automatic word_t ref_result(input instr_t ins, input word_t a, input word_t b);
        logic [3:0] opc;
        word_t      imm_s;
        word_t      imm_z;
        opc   = ins[15:12];
        imm_s = {{12{ins[3]}}, ins[3:0]};
        imm_z = {8'h00, ins[7:0]};
        case (opc)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_ADDI: return a + imm_s;
            OP_LI:   return imm_z;
            default: return 16'h0000;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////
    // Compare writebacks, then model the issued instruction
    always @(posedge clk)
    begin : compare
        reg_addr_t exp_reg;
        word_t     exp_data;
        word_t     res;
        if (!arst_n)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                model_regs[i] = '0;
            end
            exp_reg_q.delete();
            exp_data_q.delete();
            check_count      = 0;
            mismatch_count   = 0;
            unexpected_count = 0;
            leftover_count   = 0;
            error_count      = 0;
            reported         = 1'b0;
        end
        else
        begin
            if (wb_valid)
            begin
                if (exp_reg_q.size() == 0)
                begin
                    unexpected_count++;
                    $display("Writeback to r%0d at %0t arrived with nothing pending",
                             wb_reg, $time);
                end
                else
                begin
                    exp_reg  = exp_reg_q.pop_front();
                    exp_data = exp_data_q.pop_front();
                    check_count++;
                    if ((wb_reg !== exp_reg) || (wb_data !== exp_data))
                    begin
                        mismatch_count++;
                        $display("MISMATCH at %0t: expected r%0d = 0x%04h, got r%0d = 0x%04h",
                                 $time, exp_reg, exp_data, wb_reg, wb_data);
                    end
                end
            end

            if (instr_valid && ref_writes(instr))
            begin
                res = ref_result(instr, model_regs[instr[7:4]], model_regs[instr[3:0]]);
                model_regs[instr[11:8]] = res;
                exp_reg_q.push_back(instr[11:8]);
                exp_data_q.push_back(res);
            end

            if (end_of_test && !reported)
            begin
                leftover_count = exp_reg_q.size();
                if (leftover_count != 0)
                    $display("%0d expected writebacks never arrived", leftover_count);
                error_count = mismatch_count + unexpected_count + leftover_count;
                $display("Checks %0d, mismatches %0d, unexpected %0d, missing %0d, errors %0d",
                         check_count, mismatch_count, unexpected_count, leftover_count,
                         error_count);
                reported = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/pipeline_top.sv */
`default_nettype none

module pipeline_top (
    input  wire logic              clk,
    input  wire logic              arst_n,
    input  wire pipe_pkg::instr_t  instr,
    input  wire logic              instr_valid,
    output logic                   wb_valid,
    output pipe_pkg::reg_addr_t    wb_reg,
    output pipe_pkg::word_t        wb_data
);
    import pipe_pkg::*;

    // Register file read ports
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;

    // Execute register contents
    logic      ex_valid;
    opcode_e   ex_op;
    reg_addr_t ex_rd;
    reg_addr_t ex_rs1;
    reg_addr_t ex_rs2;
    word_t     ex_a;
    word_t     ex_b;
    word_t     ex_imm;

    logic      fwd_a;
    logic      fwd_b;

    decode_stage _decode (
        .clk (clk), .arst_n (arst_n),
        .instr (instr), .instr_valid (instr_valid),
        .rs1_addr (rs1_addr), .rs2_addr (rs2_addr),
        .rs1_data (rs1_data), .rs2_data (rs2_data),
        .ex_valid (ex_valid), .ex_op (ex_op), .ex_rd (ex_rd),
        .ex_rs1 (ex_rs1), .ex_rs2 (ex_rs2),
        .ex_a (ex_a), .ex_b (ex_b), .ex_imm (ex_imm)
    );

    // Write port fed straight from the writeback register
    regfile _regfile (
        .clk (clk), .arst_n (arst_n),
        .rs1_addr (rs1_addr), .rs2_addr (rs2_addr),
        .rs1_data (rs1_data), .rs2_data (rs2_data),
        .we (wb_valid), .wr_addr (wb_reg), .wr_data (wb_data)
    );

    forward_unit _forward (
        .ex_valid (ex_valid), .ex_op (ex_op),
        .ex_rs1 (ex_rs1), .ex_rs2 (ex_rs2),
        .wb_valid (wb_valid), .wb_reg (wb_reg),
        .fwd_a (fwd_a), .fwd_b (fwd_b)
    );

    execute_stage _execute (
        .clk (clk), .arst_n (arst_n),
        .ex_valid (ex_valid), .ex_op (ex_op), .ex_rd (ex_rd),
        .ex_a (ex_a), .ex_b (ex_b), .ex_imm (ex_imm),
        .fwd_a (fwd_a), .fwd_b (fwd_b),
        .wb_valid (wb_valid), .wb_reg (wb_reg), .wb_data (wb_data)
    );

endmodule

`default_nettype wire

/* verilog/execute_stage.sv */
`default_nettype none

module execute_stage (
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  wire logic                ex_valid,
    input  wire pipe_pkg::opcode_e   ex_op,
    input  wire pipe_pkg::reg_addr_t ex_rd,
    input  wire pipe_pkg::word_t     ex_a,
    input  wire pipe_pkg::word_t     ex_b,
    input  wire pipe_pkg::word_t     ex_imm,
    input  wire logic                fwd_a,
    input  wire logic                fwd_b,
    output logic                     wb_valid,
    output pipe_pkg::reg_addr_t      wb_reg,
    output pipe_pkg::word_t          wb_data
);
    import pipe_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t src_b;
    word_t alu_res;
    logic  writes_reg;

    //////////////////////////////////////////////////////////////
    // Operand selection
    assign op_a = fwd_a ? wb_data : ex_a;
    assign op_b = fwd_b ? wb_data : ex_b;

    // Immediate forms replace the second operand
    assign src_b = ((ex_op == OP_ADDI) || (ex_op == OP_LI)) ? ex_imm : op_b;

    //////////////////////////////////////////////////////////////
    // ALU
    always_comb
    begin
        case (ex_op)
            OP_ADD, OP_ADDI: alu_res = op_a + src_b;
            OP_SUB:          alu_res = op_a - src_b;
            OP_AND:          alu_res = op_a & src_b;
            OP_OR:           alu_res = op_a | src_b;
            OP_XOR:          alu_res = op_a ^ src_b;
            OP_LI:           alu_res = src_b;
            default:         alu_res = '0;
        endcase
    end

    assign writes_reg = ex_valid && (ex_op != OP_NOP) && (ex_rd != '0);

    //////////////////////////////////////////////////////////////
    // Writeback register
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            wb_valid <= 1'b0;
        else
            wb_valid <= writes_reg;
    end

    always_ff @(posedge clk)
    begin
        if (writes_reg)
        begin
            wb_reg  <= ex_rd;
            wb_data <= alu_res;
        end
    end

    wb_never_r0: assert property (@(posedge clk) disable iff (!arst_n)
        wb_valid |-> (wb_reg != '0));

endmodule

`default_nettype wire

/* verilog/forward_unit.sv */
`default_nettype none

module forward_unit (
    input  wire logic                ex_valid,
    input  wire pipe_pkg::opcode_e   ex_op,
    input  wire pipe_pkg::reg_addr_t ex_rs1,
    input  wire pipe_pkg::reg_addr_t ex_rs2,
    input  wire logic                wb_valid,
    input  wire pipe_pkg::reg_addr_t wb_reg,
    output logic                     fwd_a,
    output logic                     fwd_b
);
    import pipe_pkg::*;

    logic uses_rs1;
    logic uses_rs2;

    // Source fields actually read by the executing op
    always_comb
    begin
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        if (ex_valid)
        begin
            case (ex_op)
                OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR:
                begin
                    uses_rs1 = 1'b1;
                    uses_rs2 = 1'b1;
                end
                OP_ADDI:
                    uses_rs1 = 1'b1;
                default:
                    uses_rs1 = 1'b0;
            endcase
        end
    end

    // wb_valid never covers r0 or NOP
    assign fwd_a = uses_rs1 && wb_valid && (ex_rs1 == wb_reg);
    assign fwd_b = uses_rs2 && wb_valid && (ex_rs2 == wb_reg);

    always_comb
    begin
        no_fwd_when_idle: assert (ex_valid || !(fwd_a || fwd_b));
    end

endmodule

`default_nettype wire

/* verilog/decode_stage.sv */
`default_nettype none

module decode_stage (
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  wire pipe_pkg::instr_t    instr,
    input  wire logic                instr_valid,
    output pipe_pkg::reg_addr_t      rs1_addr,
    output pipe_pkg::reg_addr_t      rs2_addr,
    input  wire pipe_pkg::word_t     rs1_data,
    input  wire pipe_pkg::word_t     rs2_data,
    output logic                     ex_valid,
    output pipe_pkg::opcode_e        ex_op,
    output pipe_pkg::reg_addr_t      ex_rd,
    output pipe_pkg::reg_addr_t      ex_rs1,
    output pipe_pkg::reg_addr_t      ex_rs2,
    output pipe_pkg::word_t          ex_a,
    output pipe_pkg::word_t          ex_b,
    output pipe_pkg::word_t          ex_imm
);
    import pipe_pkg::*;

    localparam int RW = $bits(reg_addr_t);
    localparam int DW = $bits(word_t);

    logic                      id_valid;
    instr_t                    id_instr;
    logic [$bits(opcode_e)-1:0] id_opc;
    opcode_e                   dec_op;
    reg_addr_t                 dec_rd;
    word_t                     dec_imm;

    //////////////////////////////////////////////////////////////
    // Decode register
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            id_valid <= 1'b0;
        else
            id_valid <= instr_valid;
    end

    always_ff @(posedge clk)
    begin
        if (instr_valid)
            id_instr <= instr;
    end

    //////////////////////////////////////////////////////////////
    // Field extraction
    assign id_opc   = id_instr[OPC_MSB -: $bits(opcode_e)];
    assign dec_rd   = id_instr[RD_MSB -: RW];
    assign rs1_addr = id_instr[RS1_MSB -: RW];
    assign rs2_addr = id_instr[RS2_MSB -: RW];

    always_comb
    begin
        case (id_opc)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_LI:
                dec_op = opcode_e'(id_opc);
            default:
                dec_op = OP_NOP;
        endcase
    end

    // ADDI takes a signed nibble, LI a zero-extended byte
    always_comb
    begin
        case (dec_op)
            OP_ADDI: dec_imm = {{(DW - RW){id_instr[RS2_MSB]}}, id_instr[RS2_MSB -: RW]};
            OP_LI:   dec_imm = {{(DW - RS1_MSB - 1){1'b0}}, id_instr[RS1_MSB:0]};
            default: dec_imm = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////
    // Execute register
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            ex_valid <= 1'b0;
        else
            ex_valid <= id_valid;
    end

    always_ff @(posedge clk)
    begin
        if (id_valid)
        begin
            ex_op  <= dec_op;
            ex_rd  <= dec_rd;
            ex_rs1 <= rs1_addr;
            ex_rs2 <= rs2_addr;
            ex_a   <= rs1_data;
            ex_b   <= rs2_data;
            ex_imm <= dec_imm;
        end
    end

endmodule

`default_nettype wire

/* verilog/regfile.sv */
`default_nettype none

module regfile (
    input  wire logic              clk,
    input  wire logic              arst_n,
    input  wire pipe_pkg::reg_addr_t rs1_addr,
    input  wire pipe_pkg::reg_addr_t rs2_addr,
    output pipe_pkg::word_t        rs1_data,
    output pipe_pkg::word_t        rs2_data,
    input  wire logic              we,
    input  wire pipe_pkg::reg_addr_t wr_addr,
    input  wire pipe_pkg::word_t   wr_data
);
    import pipe_pkg::*;

    word_t regs [NUM_REGS];

    // Read with write-through, r0 hardwired to zero
    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0)
            return '0;
        else if (we && (wr_addr == addr))
            return wr_data;
        else
            return regs[addr];
    endfunction

    assign rs1_data = read_port(rs1_addr);
    assign rs2_data = read_port(rs2_addr);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (we && (wr_addr != '0))
        begin
            regs[wr_addr] <= wr_data;
        end
    end

    r0_stays_zero: assert property (@(posedge clk) disable iff (!arst_n) regs[0] == '0);

endmodule

`default_nettype wire

/* verilog/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

    // Data and instruction widths
    typedef logic [15:0] word_t;
    typedef logic [15:0] instr_t;
    typedef logic [3:0]  reg_addr_t;

    // Any code not listed here behaves as NOP
    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_ADD  = 4'h1,
        OP_SUB  = 4'h2,
        OP_AND  = 4'h3,
        OP_OR   = 4'h4,
        OP_XOR  = 4'h5,
        OP_ADDI = 4'h6,
        OP_LI   = 4'h7
    } opcode_e;

    localparam int NUM_REGS = 16;

    // Top bit of each instruction field
    localparam int OPC_MSB = 15;
    localparam int RD_MSB  = 11;
    localparam int RS1_MSB = 7;
    localparam int RS2_MSB = 3;

endpackage

`default_nettype wire
